/* sim/decode_golden.txt */
// grp flush stall instr | expected: opc flags(sgn imm gpwe srwe srcgp srcsr) imm12 imm14 imm10
// imm16 cc src_gp tgt_gp src_sr tgt_sr, all hex, expected values seen one edge after the row
2 0 0 01A5C3 01 0A 000 0000 000 0000 0 5 A 0 0
2 0 0 037E21 03 08 000 0000 000 0000 0 0 7 0 0
2 0 0 09B412 09 02 000 0000 000 0000 0 4 B 0 0
2 0 0 0A3C55 0A 00 000 0000 000 0000 0 0 3 0 0
2 0 0 114ABC 11 18 ABC 0000 000 0000 0 0 4 0 0
2 0 0 189123 18 10 123 0000 000 0000 0 0 9 0 0
2 0 0 1BF00D 1B 10 00D 0000 000 0000 0 0 0 0 0
2 0 0 206789 20 2A 000 0000 000 0000 0 7 6 0 0
2 0 0 231F00 23 22 000 0000 000 0000 0 F 1 0 0
2 0 0 248A00 24 28 000 0000 000 0000 0 0 8 0 0
2 0 0 25C300 25 20 000 0000 000 0000 0 0 C 0 0
2 0 0 312FFF 31 38 FFF 0000 000 0000 0 0 2 0 0
2 0 0 345800 34 30 800 0000 000 0000 0 0 0 0 0
3 0 0 507ABC 50 11 ABC 0000 000 0000 7 0 0 2 0
3 0 0 519D00 51 21 000 0000 000 0000 D 0 9 2 0
3 0 0 52E345 52 31 345 0000 000 0000 E 0 0 2 0
3 0 0 53BEEF 53 31 000 0000 000 BEEF 0 0 0 2 0
3 0 0 544A60 54 0B 000 0000 000 0000 6 A 4 2 0
3 0 0 553B77 55 09 000 0000 000 0000 B 0 3 2 0
3 0 0 732DAB 73 31 000 0000 1AB 0000 B 0 0 2 0
4 0 0 764123 76 14 123 0000 000 0000 0 0 0 0 3
4 0 0 77FFFF 77 00 000 0000 000 0000 0 0 0 0 3
4 0 0 71ABCD 71 34 000 2BCD 000 0000 0 0 0 0 2
4 0 0 724321 72 34 000 0321 000 0000 0 0 0 0 1
4 0 0 79C5AA 79 02 000 0000 000 0000 0 C 0 0 0
4 0 0 786000 78 08 000 0000 000 0000 0 0 6 0 0
4 0 0 70E300 70 05 000 0000 000 0000 0 0 0 2 3
4 0 0 747123 74 31 123 0000 000 0000 0 0 0 3 1
4 0 0 759456 75 35 456 0000 000 0000 0 0 0 1 2
4 0 0 3F1234 3F 00 000 0000 000 0000 0 0 0 0 0
4 0 0 0DFFFF 0D 00 000 0000 000 0000 0 0 0 0 0
4 0 0 9A5555 9A 00 000 0000 000 0000 0 0 0 0 0
5 0 0 01A5C3 01 0A 000 0000 000 0000 0 5 A 0 0
5 0 1 114ABC 01 0A 000 0000 000 0000 0 5 A 0 0
5 0 1 507ABC 01 0A 000 0000 000 0000 0 5 A 0 0
5 0 1 764123 01 0A 000 0000 000 0000 0 5 A 0 0
5 1 0 206789 00 00 000 0000 000 0000 0 0 0 0 0
5 0 0 52E345 52 31 345 0000 000 0000 E 0 0 2 0
5 1 1 09B412 00 00 000 0000 000 0000 0 0 0 0 0
5 0 1 09B412 00 00 000 0000 000 0000 0 0 0 0 0
5 0 0 09B412 09 02 000 0000 000 0000 0 4 B 0 0
6 0 0 312FFF 31 38 FFF 0000 000 0000 0 0 2 0 0
6 0 0 544A60 54 0B 000 0000 000 0000 6 A 4 2 0
6 0 0 77FFFF 77 00 000 0000 000 0000 0 0 0 0 3
6 0 0 1BF00D 1B 10 00D 0000 000 0000 0 0 0 0 0
6 0 0 79C5AA 79 02 000 0000 000 0000 0 C 0 0 0
6 0 0 519D00 51 21 000 0000 000 0000 D 0 9 2 0

/* verilog.f */
logic/decode_pkg.sv
logic/opcode_classify.sv
logic/field_extract.sv
logic/stage_reg.sv
logic/decode_stage.sv
sim/decode_stage_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wall -f verilog.f --top-module decode_stage_tb -o decode_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/decode_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation run returned status $status"
    exit 1
fi

if grep -q "^Simulation passed$" "$LOG"; then
    exit 0
fi
exit 1

/* sim/decode_stage_tb.sv */
module decode_stage_tb
    import decode_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int RST_CYCLES = 16;
    localparam int COLS       = 15;
    localparam int MAX_ROWS   = 128;
    localparam int MARGIN     = 20;

    logic               iw_clk;
    logic               iw_rst;
    logic [ADDR_W-1:0]  pc;
    logic [INSTR_W-1:0] instr;
    logic [OPC_W-1:0]   root_opc;
    logic               flush;
    logic               stall;
    stage_ctx_t         ctx;
    decode_fields_t     dec;

    logic [31:0] gold [0:MAX_ROWS*COLS-1];
    stage_ctx_t  ctx_pred [0:MAX_ROWS-1];
    stage_ctx_t  ctx_state;
    logic [31:0] lcg_state;
    int          n_rows;
    int          cycles;
    int          cycle_limit;
    int          err_count;
    int          check_count;
    int          grp_err;
    int          cur_grp;
    int          tests_run;
    int          tests_failed;

    decode_stage decode_stage_i (
        .iw_clk   (iw_clk),
        .iw_rst   (iw_rst),
        .pc       (pc),
        .instr    (instr),
        .root_opc (root_opc),
        .flush    (flush),
        .stall    (stall),
        .ctx      (ctx),
        .dec      (dec)
    );

    initial begin
        iw_clk = 1'b0;
    end

    always #10 iw_clk = ~iw_clk;

    // Run limit guard
    always @(posedge iw_clk) begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit) begin
            $display("Timeout: the run went past %0d cycles without finishing", cycle_limit);
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic string test_name(input int g);
        case (g)
            1: return "reset clears outputs";
            2: return "ALU classes 0 to 3";
            3: return "branches and conditional moves";
            4: return "special-register and CSR ops";
            5: return "stall and flush";
            6: return "back-to-back loads";
            default: return "unknown";
        endcase
    endfunction

    task automatic compare(input string what, input logic [63:0] got, input logic [63:0] exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            grp_err++;
            $display("ERROR at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic start_test(input int g);
        cur_grp = g;
        grp_err = 0;
    endtask

    task automatic finish_test();
        tests_run++;
        if (grp_err != 0) begin
            tests_failed++;
            $display("test %0d %s: FAIL (%0d errors)", cur_grp, test_name(cur_grp), grp_err);
        end else begin
            $display("test %0d %s: PASS", cur_grp, test_name(cur_grp));
        end
    endtask

    // Compare every output field against one expected payload
    task automatic check_outputs(input stage_ctx_t ectx, input decode_fields_t edec);
        compare("ctx", 64'(ctx), 64'(ectx));
        compare("dec.opc", 64'(dec.opc), 64'(edec.opc));
        compare("dec.sgn_en", 64'(dec.sgn_en), 64'(edec.sgn_en));
        compare("dec.imm_en", 64'(dec.imm_en), 64'(edec.imm_en));
        compare("dec.tgt_gp_we", 64'(dec.tgt_gp_we), 64'(edec.tgt_gp_we));
        compare("dec.tgt_sr_we", 64'(dec.tgt_sr_we), 64'(edec.tgt_sr_we));
        compare("dec.has_src_gp", 64'(dec.has_src_gp), 64'(edec.has_src_gp));
        compare("dec.has_src_sr", 64'(dec.has_src_sr), 64'(edec.has_src_sr));
        compare("dec.imm12", 64'(dec.imm12), 64'(edec.imm12));
        compare("dec.imm14", 64'(dec.imm14), 64'(edec.imm14));
        compare("dec.imm10", 64'(dec.imm10), 64'(edec.imm10));
        compare("dec.imm16", 64'(dec.imm16), 64'(edec.imm16));
        compare("dec.cc", 64'(dec.cc), 64'(edec.cc));
        compare("dec.src_gp", 64'(dec.src_gp), 64'(edec.src_gp));
        compare("dec.tgt_gp", 64'(dec.tgt_gp), 64'(edec.tgt_gp));
        compare("dec.src_sr", 64'(dec.src_sr), 64'(edec.src_sr));
        compare("dec.tgt_sr", 64'(dec.tgt_sr), 64'(edec.tgt_sr));
    endtask

    // Golden columns 4 to 14 hold the expected decode after the edge
    function automatic decode_fields_t golden_fields(input int row);
        decode_fields_t f;
        int             b;
        b = row * COLS;
        f            = '0;
        f.opc        = gold[b+4][OPC_W-1:0];
        f.sgn_en     = gold[b+5][5];
        f.imm_en     = gold[b+5][4];
        f.tgt_gp_we  = gold[b+5][3];
        f.tgt_sr_we  = gold[b+5][2];
        f.has_src_gp = gold[b+5][1];
        f.has_src_sr = gold[b+5][0];
        f.imm12      = gold[b+6][IMM12_W-1:0];
        f.imm14      = gold[b+7][IMM14_W-1:0];
        f.imm10      = gold[b+8][IMM10_W-1:0];
        f.imm16      = gold[b+9][IMM16_W-1:0];
        f.cc         = gold[b+10][CC_W-1:0];
        f.src_gp     = gold[b+11][GP_IDX_W-1:0];
        f.tgt_gp     = gold[b+12][GP_IDX_W-1:0];
        f.src_sr     = gold[b+13][SR_IDX_W-1:0];
        f.tgt_sr     = gold[b+14][SR_IDX_W-1:0];
        return f;
    endfunction

    initial begin
        iw_rst       = 1'b1;
        // A busy fetch slot while reset is held
        pc           = '1;
        instr        = {OPC_SYSCALL, 16'h4123};
        root_opc     = '1;
        flush        = 1'b0;
        stall        = 1'b0;
        cycles       = 0;
        cycle_limit  = RST_CYCLES + MAX_ROWS + MARGIN;
        err_count    = 0;
        check_count  = 0;
        tests_run    = 0;
        tests_failed = 0;
        lcg_state    = 32'h6bfbe61d;
        ctx_state    = '0;

        // Rows past the end carry a group number no test uses
        for (int i = 0; i < MAX_ROWS * COLS; i++) begin
            gold[i] = {16'hdead, i[15:0]};
        end
        $readmemh("sim/decode_golden.txt", gold);
        n_rows = 0;
        while (n_rows < MAX_ROWS && gold[n_rows*COLS] >= 1 && gold[n_rows*COLS] <= 6) begin
            n_rows++;
        end
        cycle_limit = RST_CYCLES + n_rows + MARGIN;

        repeat (RST_CYCLES) @(posedge iw_clk);
        iw_rst <= 1'b0;

        // Nothing loaded yet, so both registers still hold the reset value
        @(negedge iw_clk);
        start_test(1);
        check_outputs('0, '0);
        finish_test();
        cur_grp = 0;

        for (int i = 0; i <= n_rows; i++) begin
            @(posedge iw_clk);
            if (i < n_rows) begin
                lcg_state = lcg_next(lcg_state);
                flush    <= gold[i*COLS+1][0];
                stall    <= gold[i*COLS+2][0];
                instr    <= gold[i*COLS+3][INSTR_W-1:0];
                pc       <= lcg_state[ADDR_W-1:0];
                root_opc <= lcg_state[31:24];
                // Load, hold or clear as the stage register does
                if (gold[i*COLS+1][0]) begin
                    ctx_state = '0;
                end else if (!gold[i*COLS+2][0]) begin
                    ctx_state.pc       = lcg_state[ADDR_W-1:0];
                    ctx_state.instr    = gold[i*COLS+3][INSTR_W-1:0];
                    ctx_state.root_opc = lcg_state[31:24];
                end
                ctx_pred[i] = ctx_state;
            end
            @(negedge iw_clk);
            if (i > 0) begin
                if (gold[(i-1)*COLS] != cur_grp) begin
                    if (cur_grp != 0) begin
                        finish_test();
                    end
                    start_test(gold[(i-1)*COLS]);
                end
                check_outputs(ctx_pred[i-1], golden_fields(i - 1));
            end
        end
        if (cur_grp != 0) begin
            finish_test();
        end

        $display("tests run %0d, tests failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, check_count, err_count);
        if (err_count == 0 && n_rows > 0) begin
            $display("Simulation passed");
        end else begin
            if (n_rows == 0) begin
                $display("No stimulus rows were read from the golden file");
            end
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* logic/decode_stage.sv */
module decode_stage
    import decode_pkg::*;
(
    input  logic               iw_clk,
    input  logic               iw_rst,
    input  logic [ADDR_W-1:0]  pc,
    input  logic [INSTR_W-1:0] instr,
    input  logic [OPC_W-1:0]   root_opc,
    input  logic               flush,
    input  logic               stall,
    output stage_ctx_t         ctx,
    output decode_fields_t     dec
);

    class_flags_t   flags;
    decode_fields_t fields;
    stage_ctx_t     ctx_d;

    assign ctx_d.pc       = pc;
    assign ctx_d.instr    = instr;
    assign ctx_d.root_opc = root_opc;

    opcode_classify opcode_classify_i (
        .instr (instr),
        .flags (flags)
    );

    field_extract field_extract_i (
        .instr  (instr),
        .flags  (flags),
        .fields (fields)
    );

    // Context and decoded payload share flush and stall, so they stay aligned
    stage_reg #(
        .payload_t (stage_ctx_t)
    ) ctx_reg_i (
        .iw_clk (iw_clk),
        .iw_rst (iw_rst),
        .flush  (flush),
        .stall  (stall),
        .d      (ctx_d),
        .q      (ctx)
    );

    stage_reg #(
        .payload_t (decode_fields_t)
    ) dec_reg_i (
        .iw_clk (iw_clk),
        .iw_rst (iw_rst),
        .flush  (flush),
        .stall  (stall),
        .d      (fields),
        .q      (dec)
    );

endmodule

/* logic/stage_reg.sv */
module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     iw_clk,
    input  logic     iw_rst,
    input  logic     flush,
    input  logic     stall,
    input  payload_t d,
    output payload_t q
);

    // Flush beats stall, so a squashed slot never lingers
    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            q <= '0;
        end else if (flush) begin
            q <= '0;
        end else if (!stall) begin
            q <= d;
        end
    end

endmodule

/* logic/field_extract.sv */
module field_extract
    import decode_pkg::*;
(
    input  logic [INSTR_W-1:0] instr,
    input  class_flags_t       flags,
    output decode_fields_t     fields
);

    logic [OPC_W-1:0]    opc;
    logic [IMM12_W-1:0]  imm12;
    logic [IMM14_W-1:0]  imm14;
    logic [IMM10_W-1:0]  imm10;
    logic [IMM16_W-1:0]  imm16;
    logic [CC_W-1:0]     cc;
    logic [GP_IDX_W-1:0] src_gp;
    logic [GP_IDX_W-1:0] tgt_gp;
    logic [SR_IDX_W-1:0] src_sr;
    logic [SR_IDX_W-1:0] tgt_sr;

    assign opc = instr[OPC_LSB +: OPC_W];

    // Immediates are right-aligned and only the width varies per op
    always_comb begin
        imm12 = '0;
        imm14 = '0;
        imm10 = '0;
        imm16 = '0;
        case (opc)
            OPC_MOVui, OPC_ADDui, OPC_SUBui, OPC_ANDui, OPC_ORui, OPC_XORui,
            OPC_SHLui, OPC_SHRui, OPC_CMPui, OPC_ROLui, OPC_RORui, OPC_LUIui,
            OPC_MOVsi, OPC_ADDsi, OPC_SUBsi, OPC_SHRsi, OPC_CMPsi,
            OPC_JCCui, OPC_BCCso, OPC_SRSTso, OPC_SRLDso, OPC_SYSCALL: begin
                imm12 = instr[IMM12_W-1:0];
            end
            OPC_SRADDsi, OPC_SRSUBsi: begin
                imm14 = instr[IMM14_W-1:0];
            end
            OPC_SRJCCso: begin
                imm10 = instr[IMM10_W-1:0];
            end
            OPC_BALso: begin
                imm16 = instr[IMM16_W-1:0];
            end
            default: begin
                imm12 = '0;
            end
        endcase
    end

    // Condition code sits wherever the encoding leaves room for it
    always_comb begin
        case (opc)
            OPC_JCCui, OPC_BCCso: cc = instr[15:12];
            OPC_BCCsr, OPC_MCCsi: cc = instr[11:8];
            OPC_SRJCCso:          cc = instr[13:10];
            OPC_MCCur:            cc = instr[7:4];
            default:              cc = '0;
        endcase
    end

    assign tgt_gp = flags.has_tgt_gp ? instr[15:12] : '0;

    // CSRWR uses the upper register slot for its data source
    always_comb begin
        if (!flags.has_src_gp) begin
            src_gp = '0;
        end else if (opc == OPC_CSRWR) begin
            src_gp = instr[15:12];
        end else begin
            src_gp = instr[11:8];
        end
    end

    // SYSCALL writes the return address to LR and KRET reads it back
    always_comb begin
        if (opc inside {OPC_KRET, OPC_SYSCALL}) begin
            tgt_sr = SR_IDX_LR;
        end else if (flags.has_tgt_sr) begin
            tgt_sr = instr[15:14];
        end else begin
            tgt_sr = '0;
        end
    end

    always_comb begin
        if (flags.uses_flags) begin
            src_sr = SR_IDX_FLAGS;
        end else if (flags.has_src_sr) begin
            src_sr = instr[13:12];
        end else begin
            src_sr = '0;
        end
    end

    assign fields.opc        = opc;
    assign fields.sgn_en     = flags.sgn_en;
    assign fields.imm_en     = flags.imm_en;
    assign fields.tgt_gp_we  = flags.tgt_gp_we;
    assign fields.tgt_sr_we  = flags.tgt_sr_we;
    assign fields.has_src_gp = flags.has_src_gp;
    assign fields.has_src_sr = flags.has_src_sr;
    assign fields.imm12      = imm12;
    assign fields.imm14      = imm14;
    assign fields.imm10      = imm10;
    assign fields.imm16      = imm16;
    assign fields.cc         = cc;
    assign fields.src_gp     = src_gp;
    assign fields.tgt_gp     = tgt_gp;
    assign fields.src_sr     = src_sr;
    assign fields.tgt_sr     = tgt_sr;

endmodule

/* logic/opcode_classify.sv */
module opcode_classify
    import decode_pkg::*;
(
    input  logic [INSTR_W-1:0] instr,
    output class_flags_t       flags
);

    logic [OPC_W-1:0]     opc;
    logic [OPCLASS_W-1:0] opclass;
    logic                 known;
    logic                 is_ur;
    logic                 is_ui;
    logic                 is_sr;
    logic                 is_si;
    logic                 uses_flags;
    logic                 tgt_gp_we;
    logic                 tgt_sr_we;

    assign opc     = instr[OPC_LSB +: OPC_W];
    assign opclass = opc[OPC_W-1 -: OPCLASS_W];

    // Holes inside a class decode as no-ops, so check the exact opcode list
    always_comb begin
        case (opclass)
            OPCLASS_UR: known = opc inside {OPC_MOVur, OPC_ADDur, OPC_SUBur, OPC_NOTur,
                                            OPC_ANDur, OPC_ORur, OPC_XORur, OPC_SHLur,
                                            OPC_SHRur, OPC_CMPur, OPC_TSTur, OPC_ROLur,
                                            OPC_RORur};
            OPCLASS_UI: known = opc inside {OPC_MOVui, OPC_ADDui, OPC_SUBui, OPC_ANDui,
                                            OPC_ORui, OPC_XORui, OPC_SHLui, OPC_SHRui,
                                            OPC_CMPui, OPC_ROLui, OPC_RORui, OPC_LUIui};
            OPCLASS_SR: known = opc inside {OPC_ADDsr, OPC_SUBsr, OPC_SHRsr, OPC_CMPsr,
                                            OPC_NEGsr, OPC_TSTsr};
            OPCLASS_SI: known = opc inside {OPC_MOVsi, OPC_ADDsi, OPC_SUBsi, OPC_SHRsi,
                                            OPC_CMPsi};
            default: known = 1'b0;
        endcase
    end

    assign is_ur = known && (opclass == OPCLASS_UR);
    assign is_ui = known && (opclass == OPCLASS_UI);
    assign is_sr = known && (opclass == OPCLASS_SR);
    assign is_si = known && (opclass == OPCLASS_SI);

    // Branches and conditional moves read FLAGS implicitly
    assign uses_flags = opc inside {OPC_JCCui, OPC_BCCsr, OPC_BCCso, OPC_BALso,
                                    OPC_SRJCCso, OPC_MCCur, OPC_MCCsi};

    // Compares and tests only set FLAGS and LUIui is handled outside the GP file
    assign tgt_gp_we = (is_ur && !(opc inside {OPC_CMPur, OPC_TSTur}))
                    || (is_ui && !(opc inside {OPC_CMPui, OPC_LUIui}))
                    || (is_sr && !(opc inside {OPC_CMPsr, OPC_TSTsr}))
                    || (is_si && (opc != OPC_CMPsi))
                    || (opc inside {OPC_MCCur, OPC_MCCsi, OPC_CSRRD});

    assign tgt_sr_we = opc inside {OPC_SRMOVur, OPC_SRADDsi, OPC_SRSUBsi, OPC_SRLDso,
                                   OPC_SYSCALL};

    assign flags.sgn_en = is_sr || is_si
                       || (opc inside {OPC_BCCsr, OPC_BCCso, OPC_BALso, OPC_SRJCCso,
                                       OPC_SRADDsi, OPC_SRSUBsi, OPC_SRSTso, OPC_SRLDso});

    assign flags.imm_en = is_ui || is_si
                       || (opc inside {OPC_JCCui, OPC_BCCso, OPC_BALso, OPC_SRJCCso,
                                       OPC_SRADDsi, OPC_SRSUBsi, OPC_SRSTso, OPC_SRLDso,
                                       OPC_SYSCALL});

    assign flags.uses_flags = uses_flags;
    assign flags.tgt_gp_we  = tgt_gp_we;

    // BCCsr carries its offset register in the target field
    assign flags.has_tgt_gp = tgt_gp_we
                           || (opc inside {OPC_CMPur, OPC_TSTur, OPC_CMPui, OPC_CMPsr,
                                           OPC_TSTsr, OPC_BCCsr});

    assign flags.tgt_sr_we  = tgt_sr_we;
    assign flags.has_tgt_sr = tgt_sr_we || (opc == OPC_SRSTso);

    // NOTur and TSTur work on the target register alone
    assign flags.has_src_gp = (is_ur && !(opc inside {OPC_NOTur, OPC_TSTur}))
                           || (opc inside {OPC_ADDsr, OPC_SUBsr, OPC_SHRsr, OPC_CMPsr,
                                           OPC_MCCur, OPC_CSRWR});

    assign flags.has_src_sr = uses_flags
                           || (opc inside {OPC_SRMOVur, OPC_SRJCCso, OPC_SRLDso,
                                           OPC_SRSTso});

endmodule

/* logic/decode_pkg.sv */
package decode_pkg;

    // Datapath widths
    localparam int INSTR_W   = 24;
    localparam int ADDR_W    = 24;
    localparam int OPC_W     = 8;
    localparam int OPC_LSB   = 16;
    localparam int OPCLASS_W = 4;
    localparam int GP_IDX_W  = 4;
    localparam int SR_IDX_W  = 2;
    localparam int CC_W      = 4;
    localparam int IMM10_W   = 10;
    localparam int IMM12_W   = 12;
    localparam int IMM14_W   = 14;
    localparam int IMM16_W   = 16;

    // Special registers with a fixed role in decode
    localparam logic [SR_IDX_W-1:0] SR_IDX_FLAGS = 2'd2;
    localparam logic [SR_IDX_W-1:0] SR_IDX_LR    = 2'd3;

    // Opcode classes live in the high nibble of the opcode byte
    localparam logic [OPCLASS_W-1:0] OPCLASS_UR  = 4'h0;
    localparam logic [OPCLASS_W-1:0] OPCLASS_UI  = 4'h1;
    localparam logic [OPCLASS_W-1:0] OPCLASS_SR  = 4'h2;
    localparam logic [OPCLASS_W-1:0] OPCLASS_SI  = 4'h3;
    localparam logic [OPCLASS_W-1:0] OPCLASS_BR  = 4'h5;
    localparam logic [OPCLASS_W-1:0] OPCLASS_SYS = 4'h7;

    // Unsigned register ALU
    localparam logic [OPC_W-1:0] OPC_MOVur = 8'h00;
    localparam logic [OPC_W-1:0] OPC_ADDur = 8'h01;
    localparam logic [OPC_W-1:0] OPC_SUBur = 8'h02;
    localparam logic [OPC_W-1:0] OPC_NOTur = 8'h03;
    localparam logic [OPC_W-1:0] OPC_ANDur = 8'h04;
    localparam logic [OPC_W-1:0] OPC_ORur  = 8'h05;
    localparam logic [OPC_W-1:0] OPC_XORur = 8'h06;
    localparam logic [OPC_W-1:0] OPC_SHLur = 8'h07;
    localparam logic [OPC_W-1:0] OPC_SHRur = 8'h08;
    localparam logic [OPC_W-1:0] OPC_CMPur = 8'h09;
    localparam logic [OPC_W-1:0] OPC_TSTur = 8'h0A;
    localparam logic [OPC_W-1:0] OPC_ROLur = 8'h0B;
    localparam logic [OPC_W-1:0] OPC_RORur = 8'h0C;

    // Unsigned immediate ALU
    localparam logic [OPC_W-1:0] OPC_MOVui = 8'h10;
    localparam logic [OPC_W-1:0] OPC_ADDui = 8'h11;
    localparam logic [OPC_W-1:0] OPC_SUBui = 8'h12;
    localparam logic [OPC_W-1:0] OPC_ANDui = 8'h13;
    localparam logic [OPC_W-1:0] OPC_ORui  = 8'h14;
    localparam logic [OPC_W-1:0] OPC_XORui = 8'h15;
    localparam logic [OPC_W-1:0] OPC_SHLui = 8'h16;
    localparam logic [OPC_W-1:0] OPC_SHRui = 8'h17;
    localparam logic [OPC_W-1:0] OPC_CMPui = 8'h18;
    localparam logic [OPC_W-1:0] OPC_ROLui = 8'h19;
    localparam logic [OPC_W-1:0] OPC_RORui = 8'h1A;
    localparam logic [OPC_W-1:0] OPC_LUIui = 8'h1B;

    // Signed register ALU
    localparam logic [OPC_W-1:0] OPC_ADDsr = 8'h20;
    localparam logic [OPC_W-1:0] OPC_SUBsr = 8'h21;
    localparam logic [OPC_W-1:0] OPC_SHRsr = 8'h22;
    localparam logic [OPC_W-1:0] OPC_CMPsr = 8'h23;
    localparam logic [OPC_W-1:0] OPC_NEGsr = 8'h24;
    localparam logic [OPC_W-1:0] OPC_TSTsr = 8'h25;

    // Signed immediate ALU
    localparam logic [OPC_W-1:0] OPC_MOVsi = 8'h30;
    localparam logic [OPC_W-1:0] OPC_ADDsi = 8'h31;
    localparam logic [OPC_W-1:0] OPC_SUBsi = 8'h32;
    localparam logic [OPC_W-1:0] OPC_SHRsi = 8'h33;
    localparam logic [OPC_W-1:0] OPC_CMPsi = 8'h34;

    // Branches and conditional moves
    localparam logic [OPC_W-1:0] OPC_JCCui = 8'h50;
    localparam logic [OPC_W-1:0] OPC_BCCsr = 8'h51;
    localparam logic [OPC_W-1:0] OPC_BCCso = 8'h52;
    localparam logic [OPC_W-1:0] OPC_BALso = 8'h53;
    localparam logic [OPC_W-1:0] OPC_MCCur = 8'h54;
    localparam logic [OPC_W-1:0] OPC_MCCsi = 8'h55;

    // Special-register and system ops
    localparam logic [OPC_W-1:0] OPC_SRMOVur = 8'h70;
    localparam logic [OPC_W-1:0] OPC_SRADDsi = 8'h71;
    localparam logic [OPC_W-1:0] OPC_SRSUBsi = 8'h72;
    localparam logic [OPC_W-1:0] OPC_SRJCCso = 8'h73;
    localparam logic [OPC_W-1:0] OPC_SRSTso  = 8'h74;
    localparam logic [OPC_W-1:0] OPC_SRLDso  = 8'h75;
    localparam logic [OPC_W-1:0] OPC_SYSCALL = 8'h76;
    localparam logic [OPC_W-1:0] OPC_KRET    = 8'h77;
    localparam logic [OPC_W-1:0] OPC_CSRRD   = 8'h78;
    localparam logic [OPC_W-1:0] OPC_CSRWR   = 8'h79;

    // Operand-class flags from the opcode classifier
    typedef struct packed {
        logic sgn_en;
        logic imm_en;
        logic uses_flags;
        logic tgt_gp_we;
        logic has_tgt_gp;
        logic tgt_sr_we;
        logic has_tgt_sr;
        logic has_src_gp;
        logic has_src_sr;
    } class_flags_t;

    // Fetch context carried through the stage untouched
    typedef struct packed {
        logic [ADDR_W-1:0]  pc;
        logic [INSTR_W-1:0] instr;
        logic [OPC_W-1:0]   root_opc;
    } stage_ctx_t;

    // Decoded payload handed to the next stage
    typedef struct packed {
        logic [OPC_W-1:0]    opc;
        logic                sgn_en;
        logic                imm_en;
        logic                tgt_gp_we;
        logic                tgt_sr_we;
        logic                has_src_gp;
        logic                has_src_sr;
        logic [IMM12_W-1:0]  imm12;
        logic [IMM14_W-1:0]  imm14;
        logic [IMM10_W-1:0]  imm10;
        logic [IMM16_W-1:0]  imm16;
        logic [CC_W-1:0]     cc;
        logic [GP_IDX_W-1:0] src_gp;
        logic [GP_IDX_W-1:0] tgt_gp;
        logic [SR_IDX_W-1:0] src_sr;
        logic [SR_IDX_W-1:0] tgt_sr;
    } decode_fields_t;

endpackage
